// File: compile.f
rtl/div_pkg.sv
rtl/div_operand_prep.sv
rtl/div_restore_core.sv
rtl/div_result_sel.sv
rtl/div_ctrl.sv
rtl/div_unit.sv
testbench/div_unit_sva.sv
testbench/div_unit_tb.sv

// File: rtl/div_ctrl.sv
`timescale 1ns/10ps

module div_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                div_valid_i,
  input  div_pkg::div_op_t    div_type_i,
  input  logic                result_ready_i,
  input  logic                except,
  input  div_pkg::xlen_t      except_result,
  input  logic                quo_neg,
  input  logic                rem_neg,
  input  logic                core_done,
  input  div_pkg::xlen_t      final_result,
  output logic                core_load,
  output div_pkg::div_op_t    op_q,
  output logic                quo_neg_q,
  output logic                rem_neg_q,
  output div_pkg::xlen_t      result_o,
  output logic                div_stall_o,
  output logic                result_ok_o
);

  div_pkg::div_state_e state_q;
  div_pkg::div_state_e state_d;
  div_pkg::xlen_t      result_q;
  logic                accept;

  assign accept    = (state_q == div_pkg::ST_IDLE) & div_valid_i;
  assign core_load = accept & ~except;

  // ==================================================
  // state machine
  // ==================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      div_pkg::ST_IDLE: begin
        if (div_valid_i) begin
          state_d = except ? div_pkg::ST_FINISH : div_pkg::ST_DO_DIV;  // exceptions skip core
        end
      end
      div_pkg::ST_DO_DIV: begin
        if (core_done) begin
          state_d = div_pkg::ST_FINISH;
        end
      end
      div_pkg::ST_FINISH: begin
        if (result_ready_i) begin
          state_d = div_pkg::ST_IDLE;  // consumer took it
        end
      end
      default: state_d = div_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= div_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==================================================
  // request latches and result register
  // ==================================================
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q      <= div_type_i;  // also on exceptions
      quo_neg_q <= quo_neg;
      rem_neg_q <= rem_neg;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && except) begin
      result_q <= except_result;
    end else if (state_q == div_pkg::ST_DO_DIV && core_done) begin
      result_q <= final_result;
    end
  end

  // status levels
  assign result_ok_o = (state_q == div_pkg::ST_FINISH);
  assign div_stall_o = core_load | (state_q == div_pkg::ST_DO_DIV);
  assign result_o    = result_ok_o ? result_q : '0;  // zero outside finish

endmodule

// File: rtl/div_operand_prep.sv
`timescale 1ns/10ps

module div_operand_prep (
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  input  div_pkg::div_op_t div_type_i,
  output div_pkg::xlen_t   dividend_abs,
  output div_pkg::xlen_t   divisor_abs,
  output div_pkg::xlen_t   except_result,
  output logic             word_op,
  output logic             quo_neg,
  output logic             rem_neg,
  output logic             except
);

  logic           signed_op;
  logic           rem_op;
  logic           dividend_neg;
  logic           divisor_neg;
  logic           div_zero;
  logic           div_ovf;
  div_pkg::xlen_t dividend_sx;
  div_pkg::xlen_t divisor_sx;
  div_pkg::xlen_t dividend_ext;
  div_pkg::xlen_t divisor_ext;
  div_pkg::xlen_t dividend_mag;
  div_pkg::xlen_t divisor_mag;
  div_pkg::xlen_t dividend_res;

  // ==================================================
  // opcode decode
  // ==================================================
  assign word_op   = |(div_type_i & (div_pkg::OP_DIVUW | div_pkg::OP_DIVW |
                                     div_pkg::OP_REMUW | div_pkg::OP_REMW));
  assign signed_op = |(div_type_i & (div_pkg::OP_DIV | div_pkg::OP_DIVW |
                                     div_pkg::OP_REM | div_pkg::OP_REMW));
  assign rem_op    = |(div_type_i & (div_pkg::OP_REM | div_pkg::OP_REMU |
                                     div_pkg::OP_REMUW | div_pkg::OP_REMW));

  assign dividend_sx = {{32{dividend_i[31]}}, dividend_i[31:0]};
  assign divisor_sx  = {{32{divisor_i[31]}}, divisor_i[31:0]};

  // word operands are widened by their signedness
  always_comb begin
    dividend_ext = dividend_i;
    divisor_ext  = divisor_i;
    if (word_op) begin
      dividend_ext = signed_op ? dividend_sx : {32'h0, dividend_i[31:0]};
      divisor_ext  = signed_op ? divisor_sx  : {32'h0, divisor_i[31:0]};
    end
  end

  // ==================================================
  // magnitudes and result signs
  // ==================================================
  assign dividend_neg = signed_op & dividend_ext[63];
  assign divisor_neg  = signed_op & divisor_ext[63];
  assign dividend_mag = dividend_neg ? (~dividend_ext + 64'd1) : dividend_ext;
  assign divisor_mag  = divisor_neg  ? (~divisor_ext + 64'd1)  : divisor_ext;

  assign dividend_abs = word_op ? {dividend_mag[31:0], 32'h0} : dividend_mag;  // 32 steps only
  assign divisor_abs  = divisor_mag;
  assign quo_neg      = dividend_neg ^ divisor_neg;
  assign rem_neg      = dividend_neg;  // remainder follows dividend

  // ==================================================
  // divide by zero and signed overflow
  // ==================================================
  assign div_zero = word_op ? ~|divisor_i[31:0] : ~|divisor_i;
  assign div_ovf  = signed_op & (word_op ?
                    (dividend_i[31:0] == 32'h8000_0000 && &divisor_i[31:0]) :
                    (dividend_i == {1'b1, 63'h0} && &divisor_i));
  assign except   = div_zero | div_ovf;

  assign dividend_res = word_op ? dividend_sx : dividend_i;

  always_comb begin
    except_result = '0;
    if (div_zero) begin
      except_result = rem_op ? dividend_res : '1;  // quotient all ones
    end else if (div_ovf) begin
      except_result = rem_op ? '0 : dividend_res;  // quotient is the dividend
    end
  end

endmodule

// File: rtl/div_pkg.sv
package div_pkg;

  // ==================================================
  // data widths
  // ==================================================
  typedef logic [63:0]  xlen_t;      // one register word
  typedef logic [127:0] dword_t;     // remainder above quotient
  typedef logic [7:0]   div_op_t;    // one-hot opcode
  typedef logic [6:0]   iter_cnt_t;  // counts up to 64

  // ==================================================
  // one-hot opcodes
  // ==================================================
  localparam div_op_t OP_DIV   = 8'b1000_0000;  // signed 64
  localparam div_op_t OP_DIVU  = 8'b0100_0000;  // unsigned 64
  localparam div_op_t OP_DIVUW = 8'b0010_0000;  // unsigned 32
  localparam div_op_t OP_DIVW  = 8'b0001_0000;  // signed 32
  localparam div_op_t OP_REM   = 8'b0000_1000;  // signed 64
  localparam div_op_t OP_REMU  = 8'b0000_0100;  // unsigned 64
  localparam div_op_t OP_REMUW = 8'b0000_0010;  // unsigned 32
  localparam div_op_t OP_REMW  = 8'b0000_0001;  // signed 32

  // ==================================================
  // controller states
  // ==================================================
  typedef enum logic [1:0] {
    ST_IDLE   = 2'b00,  // waiting for a request
    ST_DO_DIV = 2'b01,  // core iterating
    ST_FINISH = 2'b10   // result held for the consumer
  } div_state_e;

endpackage

// File: rtl/div_restore_core.sv
`timescale 1ns/10ps

module div_restore_core (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           core_load,
  input  logic           word_op,
  input  div_pkg::xlen_t dividend_abs,
  input  div_pkg::xlen_t divisor_abs,
  output div_pkg::xlen_t quotient,
  output div_pkg::xlen_t remainder,
  output logic           core_done
);

  div_pkg::dword_t    rem_quo_q;
  div_pkg::dword_t    shifted;
  div_pkg::xlen_t     divisor_q;
  div_pkg::iter_cnt_t cnt_q;
  logic               busy_q;
  logic [64:0]        trial;  // top bit is the borrow

  assign shifted   = rem_quo_q << 1;
  assign trial     = {1'b0, shifted[127:64]} - {1'b0, divisor_q};
  assign core_done = busy_q & (cnt_q == '0);

  // ==================================================
  // iteration counter
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (core_load) begin
      busy_q <= 1'b1;
      cnt_q  <= word_op ? div_pkg::iter_cnt_t'(32) : div_pkg::iter_cnt_t'(64);
    end else if (busy_q) begin
      if (cnt_q == '0) begin
        busy_q <= 1'b0;  // done pulse lasts one cycle
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // ==================================================
  // shift and trial subtract
  // ==================================================
  always_ff @(posedge clk) begin
    if (core_load) begin
      rem_quo_q <= {64'h0, dividend_abs};
      divisor_q <= divisor_abs;
    end else if (busy_q && cnt_q != '0) begin
      if (trial[64]) begin
        rem_quo_q <= shifted;  // borrow so restore
      end else begin
        rem_quo_q <= {trial[63:0], shifted[63:1], 1'b1};
      end
    end
  end

  assign quotient  = rem_quo_q[63:0];
  assign remainder = rem_quo_q[127:64];

endmodule

// File: rtl/div_result_sel.sv
`timescale 1ns/10ps

module div_result_sel (
  input  div_pkg::div_op_t op,
  input  div_pkg::xlen_t   quotient,
  input  div_pkg::xlen_t   remainder,
  input  logic             quo_neg,
  input  logic             rem_neg,
  output div_pkg::xlen_t   final_result
);

  logic           rem_op;
  logic           word_op;
  logic           negate;
  div_pkg::xlen_t raw;
  div_pkg::xlen_t signed_val;

  assign rem_op  = |(op & (div_pkg::OP_REM | div_pkg::OP_REMU |
                           div_pkg::OP_REMUW | div_pkg::OP_REMW));
  assign word_op = |(op & (div_pkg::OP_DIVUW | div_pkg::OP_DIVW |
                           div_pkg::OP_REMUW | div_pkg::OP_REMW));

  // pick quotient or remainder with its own sign
  assign raw    = rem_op ? remainder : quotient;
  assign negate = rem_op ? rem_neg : quo_neg;

  assign signed_val = negate ? (~raw + 64'd1) : raw;

  // ==================================================
  // word results take bit 31 upward
  // ==================================================
  assign final_result = word_op ? {{32{signed_val[31]}}, signed_val[31:0]} : signed_val;

endmodule

// File: rtl/div_unit.sv
`timescale 1ns/10ps

module div_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             div_valid_i,
  input  div_pkg::div_op_t div_type_i,
  input  div_pkg::xlen_t   dividend_i,
  input  div_pkg::xlen_t   divisor_i,
  input  logic             result_ready_i,
  output div_pkg::xlen_t   result_o,
  output logic             div_stall_o,
  output logic             result_ok_o
);

  div_pkg::xlen_t   dividend_abs;
  div_pkg::xlen_t   divisor_abs;
  div_pkg::xlen_t   except_result;
  div_pkg::xlen_t   quotient;
  div_pkg::xlen_t   remainder;
  div_pkg::xlen_t   final_result;
  div_pkg::div_op_t op_q;
  logic             word_op;
  logic             quo_neg;
  logic             rem_neg;
  logic             except;
  logic             core_load;
  logic             core_done;
  logic             quo_neg_q;
  logic             rem_neg_q;

  // ==================================================
  // operand side
  // ==================================================
  div_operand_prep u_prep (
    .dividend_i    (dividend_i),
    .divisor_i     (divisor_i),
    .div_type_i    (div_type_i),
    .dividend_abs  (dividend_abs),
    .divisor_abs   (divisor_abs),
    .except_result (except_result),
    .word_op       (word_op),
    .quo_neg       (quo_neg),
    .rem_neg       (rem_neg),
    .except        (except)
  );

  div_restore_core u_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_load    (core_load),
    .word_op      (word_op),
    .dividend_abs (dividend_abs),
    .divisor_abs  (divisor_abs),
    .quotient     (quotient),
    .remainder    (remainder),
    .core_done    (core_done)
  );

  // ==================================================
  // result side
  // ==================================================
  div_result_sel u_sel (
    .op           (op_q),       // latched opcode
    .quotient     (quotient),
    .remainder    (remainder),
    .quo_neg      (quo_neg_q),
    .rem_neg      (rem_neg_q),
    .final_result (final_result)
  );

  div_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_type_i     (div_type_i),
    .result_ready_i (result_ready_i),
    .except         (except),
    .except_result  (except_result),
    .quo_neg        (quo_neg),
    .rem_neg        (rem_neg),
    .core_done      (core_done),
    .final_result   (final_result),
    .core_load      (core_load),
    .op_q           (op_q),
    .quo_neg_q      (quo_neg_q),
    .rem_neg_q      (rem_neg_q),
    .result_o       (result_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal --top-module div_unit_tb -f compile.f -o div_sim \
  && obj_dir/div_sim +verilator+error+limit+1000 \
     | awk '{ print } /^Test passed$/ { ok = 1 } END { exit !ok }' \
  || exit 1

// File: testbench/div_unit_sva.sv
`timescale 1ns/10ps

module div_unit_sva (
  input logic           clk,
  input logic           rst_n,
  input logic           div_valid_i,
  input logic           result_ready_i,
  input div_pkg::xlen_t result_i,
  input logic           stall_i,
  input logic           result_ok_i,
  input logic           except_i,
  input logic           word_op_i,
  input logic           core_load_i
);

  int fail_count = 0;  // read by the testbench at the end

  // ==================================================
  // reset and idle state
  // ==================================================
  a_reset: assert property (@(posedge clk) rst_n |=> !result_ok_i && !stall_i)
    else begin
      fail_count = fail_count + 1;
      $error("status outputs high after reset");
    end

  a_zero: assert property (@(posedge clk) disable iff (rst_n) !result_ok_i |-> result_i == '0)
    else begin
      fail_count = fail_count + 1;
      $error("result_o nonzero while result_ok_o is low");
    end

  // ==================================================
  // latency and hold
  // ==================================================
  a_lat64: assert property (@(posedge clk) disable iff (rst_n)
                            core_load_i && !word_op_i |-> ##66 $rose(result_ok_i))
    else begin
      fail_count = fail_count + 1;
      $error("64-bit result did not appear after 66 edges");
    end

  a_lat32: assert property (@(posedge clk) disable iff (rst_n)
                            core_load_i && word_op_i |-> ##34 $rose(result_ok_i))
    else begin
      fail_count = fail_count + 1;
      $error("word result did not appear after 34 edges");
    end

  // exception accepted in idle answers on the next edge without a stall
  a_except: assert property (@(posedge clk) disable iff (rst_n)
                             div_valid_i && except_i && !result_ok_i && !$past(stall_i)
                             |-> !stall_i ##1 (result_ok_i && !stall_i))
    else begin
      fail_count = fail_count + 1;
      $error("exception result late or unit stalled");
    end

  a_hold: assert property (@(posedge clk) disable iff (rst_n)
                           result_ok_i && !result_ready_i |=> result_ok_i && $stable(result_i))
    else begin
      fail_count = fail_count + 1;
      $error("result dropped or changed under back-pressure");
    end

endmodule

bind div_unit div_unit_sva sva0 (
  .clk            (clk),
  .rst_n          (rst_n),
  .div_valid_i    (div_valid_i),
  .result_ready_i (result_ready_i),
  .result_i       (result_o),
  .stall_i        (div_stall_o),
  .result_ok_i    (result_ok_o),
  .except_i       (except),
  .word_op_i      (word_op),
  .core_load_i    (core_load)
);

// File: testbench/div_unit_tb.sv
`timescale 1ns/10ps

module div_unit_tb;

  localparam int clk_period   = 40;
  localparam int num_requests = 40;
  localparam int max_cycles   = 70;  // per request with slack

  logic             clk;
  logic             rst_n;
  logic             div_valid_i;
  div_pkg::div_op_t div_type_i;
  div_pkg::xlen_t   dividend_i;
  div_pkg::xlen_t   divisor_i;
  logic             result_ready_i;
  div_pkg::xlen_t   result_o;
  logic             div_stall_o;
  logic             result_ok_o;

  int             seed;
  int             errors;
  int             requests;
  int             sva_fails;
  int             i;
  div_pkg::xlen_t a;
  div_pkg::xlen_t b;
  div_pkg::xlen_t sh;

  div_unit dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_type_i     (div_type_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(num_requests * max_cycles * clk_period + 50 * clk_period);
    $display("run did not finish within the time limit");
    $display("Test failed");
    $finish;
  end

  function automatic div_pkg::xlen_t rnd64();
    return {$random(seed), $random(seed)};
  endfunction

  // ==================================================
  // ISA reference in 65-bit signed math
  // ==================================================
  function automatic div_pkg::xlen_t model_result(input div_pkg::div_op_t op,
                                                  input div_pkg::xlen_t x_in,
                                                  input div_pkg::xlen_t y_in,
                                                  output int latency);
    logic               is_w;
    logic               is_s;
    logic               is_rem;
    logic signed [64:0] x;
    logic signed [64:0] y;
    logic signed [64:0] q;
    logic signed [64:0] r;
    div_pkg::xlen_t     v;
    is_w   = |(op & (div_pkg::OP_DIVUW | div_pkg::OP_DIVW |
                     div_pkg::OP_REMUW | div_pkg::OP_REMW));
    is_s   = |(op & (div_pkg::OP_DIV | div_pkg::OP_DIVW |
                     div_pkg::OP_REM | div_pkg::OP_REMW));
    is_rem = |(op & (div_pkg::OP_REM | div_pkg::OP_REMU |
                     div_pkg::OP_REMUW | div_pkg::OP_REMW));
    if (is_w) begin
      x = is_s ? {{33{x_in[31]}}, x_in[31:0]} : {33'h0, x_in[31:0]};
      y = is_s ? {{33{y_in[31]}}, y_in[31:0]} : {33'h0, y_in[31:0]};
    end else begin
      x = is_s ? {x_in[63], x_in} : {1'b0, x_in};
      y = is_s ? {y_in[63], y_in} : {1'b0, y_in};
    end
    latency = is_w ? 34 : 66;
    if (y == 0) begin
      q = -1;  // all ones quotient
      r = x;
      latency = 1;
    end else begin
      q = x / y;  // truncates toward zero
      r = x % y;
      if (is_s && q == (65'sd1 <<< (is_w ? 31 : 63))) begin
        latency = 1;  // signed overflow
      end
    end
    v = is_rem ? r[63:0] : q[63:0];
    return is_w ? {{32{v[31]}}, v[31:0]} : v;
  endfunction

  // one request with optional back-pressure and ignored strobes
  task automatic run_request(input div_pkg::div_op_t op, input div_pkg::xlen_t x,
                             input div_pkg::xlen_t y, input int hold, input bit poke);
    div_pkg::xlen_t exp_val;
    int             exp_lat;
    int             edges;
    exp_val = model_result(op, x, y, exp_lat);
    requests++;
    @(negedge clk);
    div_valid_i    = 1'b1;
    div_type_i     = op;
    dividend_i     = x;
    divisor_i      = y;
    result_ready_i = 1'b0;
    @(posedge clk);
    edges = 1;  // accepting edge
    @(negedge clk);
    div_valid_i = 1'b0;
    while (!result_ok_o && edges < 80) begin
      assert (div_stall_o) else begin
        errors++;
        $display("error at %0t ns: div_stall_o expected 1, got %b", $time, div_stall_o);
      end
      if (poke && edges == 8) begin
        div_valid_i = 1'b1;  // must be ignored in DO_DIV
        div_type_i  = div_pkg::OP_DIVU;
        dividend_i  = 64'd1;
        divisor_i   = 64'd1;
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
      div_valid_i = 1'b0;
    end
    assert (result_ok_o) else begin
      errors++;
      $display("no result within %0d cycles of the request", edges);
    end
    if (result_ok_o) begin
      assert (edges == exp_lat) else begin
        errors++;
        $display("error at %0t ns: latency expected %0d, got %0d", $time, exp_lat, edges);
      end
      assert (!div_stall_o) else begin
        errors++;
        $display("error at %0t ns: div_stall_o expected 0, got %b", $time, div_stall_o);
      end
      assert (result_o == exp_val) else begin
        errors++;
        $display("error at %0t ns: result_o expected %h, got %h", $time, exp_val, result_o);
      end
      repeat (hold) begin
        div_valid_i = poke;  // ignored in FINISH
        @(posedge clk);
        @(negedge clk);
        div_valid_i = 1'b0;
        assert (result_ok_o && result_o == exp_val) else begin
          errors++;
          $display("error at %0t ns: result_o expected %h, got %h", $time, exp_val, result_o);
        end
      end
      result_ready_i = 1'b1;
      @(posedge clk);
      @(negedge clk);
      result_ready_i = 1'b0;
      assert (!result_ok_o && result_o == '0) else begin
        errors++;
        $display("result still shown after it was consumed at %0t ns", $time);
      end
    end
  endtask

  initial begin
    seed           = 32'h84b4;
    errors         = 0;
    requests       = 0;
    rst_n          = 1'b1;
    div_valid_i    = 1'b0;
    div_type_i     = '0;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    repeat (3) begin
      @(negedge clk);
      assert (!result_ok_o && !div_stall_o) else begin
        errors++;
        $display("status outputs high after reset at %0t ns", $time);
      end
    end

    // ==================================================
    // unsigned 64-bit
    // ==================================================
    run_request(div_pkg::OP_DIVU, 64'd100, 64'd7, 0, 1'b0);
    run_request(div_pkg::OP_REMU, 64'd100, 64'd7, 0, 1'b0);
    run_request(div_pkg::OP_DIVU, '1, 64'd3, 0, 1'b0);
    run_request(div_pkg::OP_REMU, 64'd5, '1, 0, 1'b0);
    for (i = 0; i < 3; i++) begin
      a  = rnd64();
      sh = rnd64();
      b  = rnd64() >> sh[5:0];
      run_request(div_pkg::OP_DIVU, a, b, 0, 1'b0);
      run_request(div_pkg::OP_REMU, a, b, 0, 1'b0);
    end

    // signed 64-bit with every sign pair
    for (i = 0; i < 4; i++) begin
      a = rnd64() >> 1;
      b = rnd64() >> 33;
      if (i[0]) a = -a;
      if (i[1]) b = -b;
      run_request(div_pkg::OP_DIV, a, b, 0, 1'b0);
      run_request(div_pkg::OP_REM, a, b, 0, 1'b0);
    end

    // word ops with junk in the upper halves
    for (i = 0; i < 2; i++) begin
      a  = rnd64();
      b  = rnd64();
      sh = rnd64();
      b[31:0] = b[31:0] >> sh[4:0];
      run_request(div_pkg::OP_DIVW, a, b, 0, 1'b0);
      run_request(div_pkg::OP_DIVUW, a, b, 0, 1'b0);
      run_request(div_pkg::OP_REMW, a, b, 0, 1'b0);
      run_request(div_pkg::OP_REMUW, a, b, 0, 1'b0);
    end

    // ==================================================
    // exceptions
    // ==================================================
    a = rnd64();
    run_request(div_pkg::OP_DIV, a, 64'd0, 0, 1'b0);
    run_request(div_pkg::OP_REMU, a, 64'd0, 0, 1'b0);
    run_request(div_pkg::OP_DIV, 64'h8000_0000_0000_0000, '1, 0, 1'b0);
    run_request(div_pkg::OP_REM, 64'h8000_0000_0000_0000, '1, 0, 1'b0);
    run_request(div_pkg::OP_DIVW, a, 64'hffff_ffff_0000_0000, 0, 1'b0);  // low word zero
    run_request(div_pkg::OP_REMUW, a, 64'h0000_0001_0000_0000, 0, 1'b0);
    run_request(div_pkg::OP_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff, 0, 1'b0);
    run_request(div_pkg::OP_REMW, 64'hffff_ffff_8000_0000, 64'h5555_5555_ffff_ffff, 0, 1'b0);

    // back-pressure with stray strobes
    run_request(div_pkg::OP_DIV, rnd64(), rnd64() >> 20, 6, 1'b1);
    run_request(div_pkg::OP_REMUW, rnd64(), rnd64(), 5, 1'b1);
    run_request(div_pkg::OP_DIVU, rnd64(), 64'd0, 4, 1'b1);

    repeat (2) @(negedge clk);
    sva_fails = dut0.sva0.fail_count;
    $display("requests %0d, errors %0d, assertion failures %0d", requests, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
